//--- build.f
design/gteSatPkg.sv
design/satFlagClip.sv
design/satCmdFifo.sv
design/satApbRegs.sv
design/satPipe.sv
design/gteSatTop.sv
tb/gteSatTb.sv

//--- design/gteSatPkg.sv
package gteSatPkg;

	localparam int APB_AW = 8; // APB address width.

	// Clip target of a command.
	typedef enum logic [1:0] {
		opIrColor = 2'd0, // IR clamp plus color.
		opOtz     = 2'd1, // Ordering table Z.
		opIr0     = 2'd2, // Depth cue factor.
		opSxy     = 2'd3  // Screen coordinate.
	} satOpE;

	typedef struct packed {
		logic signed [44:0] value;   // Accumulator, two's complement.
		satOpE              op;
		logic               sf;      // Shift fraction by 12.
		logic               lm;      // Limit IR to positive.
		logic               fixedSf; // IR flag as if sf=1, lm=0.
	} satCmdT;

	// First member is the MSB, so macOver lands in bit 0.
	typedef struct packed {
		logic sxySat;
		logic otzSat;
		logic colSat;
		logic irSat;
		logic macUnder;
		logic macOver;
	} satFlagsT;

	typedef struct packed {
		logic [15:0] clamp16;
		logic [7:0]  clampCol;
		satFlagsT    flags;
	} satResT;

	localparam logic [APB_AW-1:0] REG_VAL_LO = 8'h00; // Value bits 31..0.
	localparam logic [APB_AW-1:0] REG_VAL_HI = 8'h04; // Value bits 44..32.
	localparam logic [APB_AW-1:0] REG_CTRL   = 8'h08;
	localparam logic [APB_AW-1:0] REG_CMD    = 8'h0C; // Write enqueues.
	localparam logic [APB_AW-1:0] REG_RESULT = 8'h10; // Read consumes.
	localparam logic [APB_AW-1:0] REG_FLAGS  = 8'h14; // Write clears.
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h18;

endpackage

//--- design/gteSatTop.sv
`timescale 1ns/10ps
module gteSatTop #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                         i_clk,
	input  logic                         i_reset,
	input  logic                         i_psel,
	input  logic                         i_penable,
	input  logic                         i_pwrite,
	input  logic [gteSatPkg::APB_AW-1:0] i_paddr,
	input  logic [31:0]                  i_pwdata,
	output logic [31:0]                  o_prdata,
	output logic                         o_pready,
	output logic                         o_pslverr
);
	import gteSatPkg::*;

	satCmdT     cmd;
	satCmdT     head;
	satResT     res;
	logic       push;
	logic       pop;
	logic       fifoFull;
	logic       fifoEmpty;
	logic [3:0] fifoCount;
	logic       resValid;
	logic       resAccept;
	logic       pipeBusy;

	satApbRegs u_satApbRegs (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_psel      (i_psel),
		.i_penable   (i_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.i_fifoFull  (fifoFull),
		.i_fifoCount (fifoCount),
		.i_res       (res),
		.i_resValid  (resValid),
		.i_pipeBusy  (pipeBusy),
		.o_prdata    (o_prdata),
		.o_pready    (o_pready),
		.o_pslverr   (o_pslverr),
		.o_cmd       (cmd),
		.o_push      (push),
		.o_resAccept (resAccept)
	);

	satCmdFifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_satCmdFifo (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_push  (push),
		.i_din   (cmd),
		.i_pop   (pop),
		.o_dout  (head),
		.o_empty (fifoEmpty),
		.o_full  (fifoFull),
		.o_count (fifoCount)
	);

	satPipe u_satPipe (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_head      (head),
		.i_empty     (fifoEmpty),
		.i_resAccept (resAccept),
		.o_pop       (pop),
		.o_res       (res),
		.o_resValid  (resValid),
		.o_pipeBusy  (pipeBusy)
	);

endmodule

//--- design/satApbRegs.sv
`timescale 1ns/10ps
module satApbRegs (
	input  logic                         i_clk,
	input  logic                         i_reset,
	input  logic                         i_psel,
	input  logic                         i_penable,
	input  logic                         i_pwrite,
	input  logic [gteSatPkg::APB_AW-1:0] i_paddr,
	input  logic [31:0]                  i_pwdata,
	input  logic                         i_fifoFull,
	input  logic [3:0]                   i_fifoCount,
	input  gteSatPkg::satResT            i_res,
	input  logic                         i_resValid,
	input  logic                         i_pipeBusy,
	output logic [31:0]                  o_prdata,
	output logic                         o_pready,
	output logic                         o_pslverr,
	output gteSatPkg::satCmdT            o_cmd,
	output logic                         o_push,
	output logic                         o_resAccept
);
	import gteSatPkg::*;

	logic        access;
	logic        wrAcc;
	logic        rdAcc;
	logic        cmdWrite;     // Any write to REG_CMD.
	logic        resRead;      // Any read of REG_RESULT.
	logic        resLoad;
	logic        slotFull;     // Reported as resultReady.
	logic [15:0] slotClamp16;
	logic [7:0]  slotClampCol;
	satFlagsT    stickyFlags;
	logic [44:0] valueReg;
	satOpE       opReg;
	logic        sfReg;
	logic        lmReg;
	logic        fixedSfReg;

	assign access   = i_psel && i_penable; // Zero wait states.
	assign wrAcc    = access && i_pwrite;
	assign rdAcc    = access && !i_pwrite;
	assign cmdWrite = wrAcc && (i_paddr == REG_CMD);
	assign resRead  = rdAcc && (i_paddr == REG_RESULT);

	assign o_pready    = 1'b1;
	assign o_push      = cmdWrite && !i_fifoFull; // Dropped when full.
	assign o_resAccept = !slotFull;
	assign resLoad     = i_resValid && o_resAccept;
	assign o_pslverr   = (cmdWrite && i_fifoFull) || (resRead && !slotFull);

	assign o_cmd = '{value: valueReg, op: opReg, sf: sfReg, lm: lmReg, fixedSf: fixedSfReg};

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			opReg      <= opIrColor;
			sfReg      <= 1'b0;
			lmReg      <= 1'b0;
			fixedSfReg <= 1'b0;
		end else if (wrAcc && (i_paddr == REG_CTRL)) begin
			opReg      <= satOpE'(i_pwdata[1:0]);
			sfReg      <= i_pwdata[2];
			lmReg      <= i_pwdata[3];
			fixedSfReg <= i_pwdata[4];
		end
	end

	// Accumulator value, low and high words.
	always_ff @(posedge i_clk) begin
		if (wrAcc && (i_paddr == REG_VAL_LO)) begin
			valueReg[31:0] <= i_pwdata;
		end
		if (wrAcc && (i_paddr == REG_VAL_HI)) begin
			valueReg[44:32] <= i_pwdata[12:0];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			slotFull    <= 1'b0;
			stickyFlags <= '0;
		end else begin
			if (resRead && slotFull) begin
				slotFull <= 1'b0; // Host took it.
			end else if (resLoad) begin
				slotFull <= 1'b1;
			end
			// Clear first, so flags arriving in the same cycle survive.
			stickyFlags <= ((wrAcc && (i_paddr == REG_FLAGS)) ? '0 : stickyFlags) |
				(resLoad ? i_res.flags : '0);
		end
	end

	always_ff @(posedge i_clk) begin
		if (resLoad) begin
			slotClamp16  <= i_res.clamp16;
			slotClampCol <= i_res.clampCol;
		end
	end

	always_comb begin
		o_prdata = '0;
		if (rdAcc) begin
			case (i_paddr)
				REG_VAL_LO: o_prdata = valueReg[31:0];
				REG_VAL_HI: o_prdata = {19'd0, valueReg[44:32]};
				REG_CTRL:   o_prdata = {27'd0, fixedSfReg, lmReg, sfReg, opReg};
				REG_RESULT: o_prdata = slotFull ? {8'd0, slotClampCol, slotClamp16} : '0;
				REG_FLAGS:  o_prdata = {26'd0, stickyFlags};
				REG_STATUS: o_prdata = {23'd0, i_pipeBusy, i_fifoCount, 3'd0, slotFull};
				default:    o_prdata = '0; // REG_CMD reads zero.
			endcase
		end
	end

	// A dropped command never grows the FIFO.
	assert property (@(posedge i_clk) disable iff (i_reset)
		(cmdWrite && i_fifoFull) |=> (i_fifoCount <= $past(i_fifoCount)));
	// Error only in an access cycle that follows its setup.
	assert property (@(posedge i_clk) disable iff (i_reset)
		o_pslverr |-> (i_psel && i_penable && $past(i_psel && !i_penable)));

endmodule

//--- design/satCmdFifo.sv
`timescale 1ns/10ps
module satCmdFifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_push,
	input  gteSatPkg::satCmdT i_din,
	input  logic              i_pop,
	output gteSatPkg::satCmdT o_dout,
	output logic              o_empty,
	output logic              o_full,
	output logic [3:0]        o_count
);
	import gteSatPkg::*;

	localparam int AW = $clog2(FIFO_DEPTH); // Index bits, wrap bit on top.

	satCmdT      mem [FIFO_DEPTH];
	logic [AW:0] wrPtr;
	logic [AW:0] rdPtr;
	logic [AW:0] used;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (i_push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (i_pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_push) begin
			mem[wrPtr[AW-1:0]] <= i_din;
		end
	end

	assign used    = wrPtr - rdPtr;
	assign o_count = 4'(used);
	assign o_empty = (wrPtr == rdPtr);
	// Same slot, other lap.
	assign o_full  = (wrPtr[AW] != rdPtr[AW]) && (wrPtr[AW-1:0] == rdPtr[AW-1:0]);
	assign o_dout  = mem[rdPtr[AW-1:0]]; // Head entry.

	assert property (@(posedge i_clk) disable iff (i_reset) !(i_pop && o_empty));
	assert property (@(posedge i_clk) disable iff (i_reset) !(i_push && o_full));

endmodule

//--- design/satFlagClip.sv
`timescale 1ns/10ps
module satFlagClip (
	input  gteSatPkg::satCmdT i_cmd,
	output gteSatPkg::satResT o_res
);
	import gteSatPkg::*;

	logic [44:0] v;
	logic        macOver;
	logic        macUnder;
	logic [31:0] postSf;   // Value after optional shift.
	logic        irNeg;
	logic        irOver;   // Above +7FFF.
	logic        irUnder;  // Below -8000.
	logic        fixOver;
	logic        fixUnder;
	logic        colOver;  // Value/16 above FF.
	logic [19:0] lo20;
	logic [15:0] lo16;
	logic        isOver;
	logic        isUnder;

	assign v = i_cmd.value;

	// Accumulator fits in 32 bits only if 44..31 agree.
	assign macOver  = !v[44] && (|v[43:31]);
	assign macUnder = v[44] && !(&v[43:31]);

	assign postSf  = i_cmd.sf ? v[43:12] : v[31:0];
	assign irNeg   = postSf[31];
	assign irOver  = !postSf[31] && (|postSf[30:15]);
	assign irUnder = postSf[31] && !(&postSf[30:15]);
	assign colOver = !postSf[31] && (|postSf[30:12]);

	// Always shifted path for the IR flag.
	assign fixOver  = !v[43] && (|v[42:27]);
	assign fixUnder = v[43] && !(&v[42:27]);

	assign lo20 = v[19:0];
	assign lo16 = v[15:0];

	// Range check for the low-bit targets.
	always_comb begin
		isOver  = 1'b0;
		isUnder = 1'b0;
		case (i_cmd.op)
			opOtz: begin
				isUnder = lo20[19];
				isOver  = !lo20[19] && (|lo20[18:16]);
			end
			opIr0: begin
				isUnder = lo20[19];
				isOver  = !lo20[19] && (lo20[18:0] > 19'h0_1000);
			end
			opSxy: begin
				isUnder = lo16[15] && !(&lo16[14:10]);
				isOver  = !lo16[15] && (|lo16[14:10]);
			end
			default: begin
				isOver  = 1'b0; // IR path has its own checks.
				isUnder = 1'b0;
			end
		endcase
		if (macOver) begin
			isOver  = 1'b1; // Accumulator wins.
			isUnder = 1'b0;
		end else if (macUnder) begin
			isOver  = 1'b0;
			isUnder = 1'b1;
		end
	end

	always_comb begin
		o_res                = '0;
		o_res.flags.macOver  = macOver;
		o_res.flags.macUnder = macUnder;
		case (i_cmd.op)
			opIrColor: begin
				if (irOver) begin
					o_res.clamp16 = 16'h7FFF;
				end else if (i_cmd.lm ? irNeg : irUnder) begin
					o_res.clamp16 = i_cmd.lm ? 16'h0000 : 16'h8000;
				end else begin
					o_res.clamp16 = postSf[15:0];
				end
				o_res.clampCol     = irNeg ? 8'h00 : (colOver ? 8'hFF : postSf[11:4]);
				o_res.flags.colSat = irNeg || colOver;
				o_res.flags.irSat  = i_cmd.fixedSf ? (fixOver || fixUnder) :
					(irOver || (i_cmd.lm ? irNeg : irUnder));
			end
			opOtz: begin
				o_res.clamp16      = isUnder ? 16'h0000 : (isOver ? 16'hFFFF : lo20[15:0]);
				o_res.flags.otzSat = isOver || isUnder;
			end
			opIr0: begin
				o_res.clamp16      = isUnder ? 16'h0000 : (isOver ? 16'h1000 : lo20[15:0]);
				o_res.flags.otzSat = isOver || isUnder;
			end
			default: begin
				o_res.clamp16      = isUnder ? 16'hFC00 : (isOver ? 16'h03FF : lo16);
				o_res.flags.sxySat = isOver || isUnder; // Screen XY.
			end
		endcase
	end

endmodule

//--- design/satPipe.sv
`timescale 1ns/10ps
module satPipe (
	input  logic              i_clk,
	input  logic              i_reset,
	input  gteSatPkg::satCmdT i_head,
	input  logic              i_empty,
	input  logic              i_resAccept,
	output logic              o_pop,
	output gteSatPkg::satResT o_res,
	output logic              o_resValid,
	output logic              o_pipeBusy
);
	import gteSatPkg::*;

	satCmdT s1Cmd;    // Popped command.
	logic   s1Valid;
	satResT clipRes;
	logic   s2Valid;
	logic   s2Adv;    // Stage 2 free or leaving.

	satFlagClip u_satFlagClip (
		.i_cmd (s1Cmd),
		.o_res (clipRes)
	);

	assign s2Adv = !s2Valid || i_resAccept;
	// Stage 1 moves only together with stage 2.
	assign o_pop = !i_empty && s2Adv;

	assign o_resValid = s2Valid;
	assign o_pipeBusy = s1Valid || s2Valid;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else if (s2Adv) begin
			s1Valid <= o_pop;
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_pop) begin
			s1Cmd <= i_head;
		end
		if (s2Adv && s1Valid) begin
			o_res <= clipRes; // Held while stalled.
		end
	end

	// Offered result must not change until the slot takes it.
	assert property (@(posedge i_clk) disable iff (i_reset)
		(o_resValid && !i_resAccept) |=> (o_resValid && $stable(o_res)));

endmodule

//--- tb/gteSatTb.sv
`timescale 1ns/10ps
module gteSatTb;
	import gteSatPkg::*;

	localparam int FIFO_DEPTH    = 4;
	localparam int CLK_PERIOD    = 8;
	localparam int POLL_LIMIT    = 16;             // Status reads before giving up.
	localparam int RUN_CMDS      = 40 + 16 + 18 + 2; // Single commands, tests 2 to 4.
	localparam int XFER_PER_CMD  = 12;             // Four writes, polls, two reads, clear.
	localparam int PLANNED_XFERS = RUN_CMDS * XFER_PER_CMD + 8 * (FIFO_DEPTH + 3) + 24;
	localparam int WATCHDOG_NS   = PLANNED_XFERS * 2 * CLK_PERIOD * 4;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] lfsrState = 32'h3596_6272;
	string       chkName;   // Captured check, judged at the next rising edge.
	logic [31:0] chkExp;
	logic [31:0] chkAct;
	logic        chkStb;
	int          errCount;
	int          checkCount;
	int          testCount;
	string       testName;
	int          testErr0;
	int          testChk0;
	logic [5:0]  stickyExp; // Expected sticky flag register.
	logic [31:0] rd;
	logic        err;
	logic [44:0] bpVal [FIFO_DEPTH+3];
	logic [4:0]  bpCtrl [FIFO_DEPTH+3];

	gteSatTop #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_gteSatTop (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Every captured value is judged here.
	assert property (@(posedge clk) chkStb |-> (chkAct === chkExp))
	else begin
		errCount++;
		$display("[FAIL] %s: expected %h, actual %h", chkName, chkExp, chkAct);
	end

	function automatic logic nextBit();
		logic fb;
		fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]; // Taps 32,22,2,1.
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] randomBits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[62:0], nextBit()};
		end
		return r;
	endfunction

	function automatic logic [44:0] widen(input logic [31:0] x);
		return {{13{x[31]}}, x}; // Sign extend to accumulator width.
	endfunction

	// Random accumulator, sign extended from a random width.
	function automatic logic [44:0] randomValue();
		logic [44:0] v;
		int          w;
		v = 45'(randomBits(45));
		w = 14 + int'(randomBits(5)); // 14..45 significant bits.
		for (int i = w; i < 45; i++) begin
			v[i] = v[w-1];
		end
		return v;
	endfunction

	function automatic longint clampLimit(input int op, input logic high);
		case (op)
			1: return high ? 64'sh0000_FFFF : 64'sd0; // OTZ.
			2: return high ? 64'sh0000_1000 : 64'sd0; // IR0.
			default: return high ? 64'sh0000_03FF : -64'sh0000_0400;
		endcase
	endfunction

	// Reference clip. Returns {clamp16, clampCol, flags}.
	function automatic logic [29:0] clipModel(input logic [44:0] v, input logic [4:0] ctrl);
		int          op;
		longint      acc;
		longint      shifted;
		longint      post;
		longint      lower;
		longint      col;
		longint      x;
		longint      lo;
		longint      hi;
		logic        sat;
		logic [15:0] c16;
		logic [7:0]  cc;
		logic [5:0]  fl;
		op      = int'(ctrl[1:0]);
		acc     = $signed({{19{v[44]}}, v});
		shifted = $signed({{32{v[43]}}, v[43:12]});
		fl      = '0;
		cc      = '0;
		fl[0]   = acc > 64'sh7FFF_FFFF;  // Too big for 32 bits.
		fl[1]   = acc < -64'sh8000_0000;
		if (op == 0) begin
			post  = ctrl[2] ? shifted : $signed({{32{v[31]}}, v[31:0]});
			lower = ctrl[3] ? 64'sd0 : -64'sd32768;
			if (post > 32767) begin
				c16 = 16'h7FFF;
			end else if (post < lower) begin
				c16 = lower[15:0];
			end else begin
				c16 = post[15:0];
			end
			fl[2] = ctrl[4] ? (shifted > 32767 || shifted < -32768) : (post > 32767 || post < lower);
			col   = post >>> 4; // Floor, small negatives still clip.
			fl[3] = col < 0 || col > 255;
			cc    = fl[3] ? (col < 0 ? 8'h00 : 8'hFF) : col[7:0];
		end else begin
			x   = (op == 3) ? $signed({{48{v[15]}}, v[15:0]}) : $signed({{44{v[19]}}, v[19:0]});
			lo  = clampLimit(op, 1'b0);
			hi  = clampLimit(op, 1'b1);
			sat = 1'b1;
			if (fl[0] || (!fl[1] && x > hi)) begin
				c16 = hi[15:0];
			end else if (fl[1] || x < lo) begin
				c16 = lo[15:0];
			end else begin
				c16 = x[15:0];
				sat = 1'b0;
			end
			if (op == 3) begin
				fl[5] = sat; // Screen XY.
			end else begin
				fl[4] = sat;
			end
		end
		return {c16, cc, fl};
	endfunction

	function automatic logic [31:0] resultWord(input logic [29:0] r);
		return {8'd0, r[13:6], r[29:14]}; // REG_RESULT layout.
	endfunction

	// Setup then access; called and returns at a falling edge.
	task automatic apbXfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#2; // Mid access cycle.
		rdata  = prdata;
		slverr = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] act);
		chkName = name;
		chkExp  = exp;
		chkAct  = act;
		chkStb  = 1'b1;
		checkCount++;
		@(negedge clk); // Assertion samples in between.
		chkStb = 1'b0;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErr0 = errCount;
		testChk0 = checkCount;
	endtask

	task automatic endTest();
		testCount++;
		$display("%-14s %0d checks, %0d errors", testName, checkCount - testChk0,
			errCount - testErr0);
	endtask

	task automatic sendCmd(input logic [44:0] v, input logic [4:0] ctrl, output logic cmdErr);
		logic [31:0] dummy;
		logic        wErr;
		apbXfer(1'b1, REG_VAL_LO, v[31:0], dummy, wErr);
		apbXfer(1'b1, REG_VAL_HI, {19'd0, v[44:32]}, dummy, wErr);
		apbXfer(1'b1, REG_CTRL, {27'd0, ctrl}, dummy, wErr);
		apbXfer(1'b1, REG_CMD, 32'd0, dummy, cmdErr);
	endtask

	task automatic waitReady(input string name);
		logic [31:0] st;
		logic        sErr;
		int          polls;
		st    = '0;
		polls = 0;
		while (!st[0] && polls < POLL_LIMIT) begin
			apbXfer(1'b0, REG_STATUS, '0, st, sErr);
			polls++;
		end
		if (!st[0]) begin
			errCount++;
			$display("%s: no result ready after %0d status polls", name, polls);
		end
	endtask

	// One command end to end, result and flags checked.
	task automatic runCmd(input string name, input logic [44:0] v, input logic [4:0] ctrl,
			input logic clearFlags);
		logic [29:0] exp;
		logic [31:0] data;
		logic        xErr;
		exp = clipModel(v, ctrl);
		sendCmd(v, ctrl, xErr);
		waitReady(name);
		apbXfer(1'b0, REG_RESULT, '0, data, xErr);
		expectEq({name, " result"}, resultWord(exp), data);
		stickyExp = stickyExp | exp[5:0];
		apbXfer(1'b0, REG_FLAGS, '0, data, xErr);
		expectEq({name, " flags"}, {26'd0, stickyExp}, data);
		if (clearFlags) begin
			apbXfer(1'b1, REG_FLAGS, '0, data, xErr);
			stickyExp = '0;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [44:0] v;
		logic [31:0] edgeVal;
		logic [29:0] expRes;
		clk        = 1'b0;
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		chkStb     = 1'b0;
		errCount   = 0;
		checkCount = 0;
		testCount  = 0;
		stickyExp  = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		beginTest("reset");
		expectEq("reset pready", 32'd1, {31'd0, pready});
		expectEq("reset pslverr", 32'd0, {31'd0, pslverr});
		apbXfer(1'b0, REG_STATUS, '0, rd, err);
		expectEq("reset status", 32'd0, rd);
		apbXfer(1'b0, REG_FLAGS, '0, rd, err);
		expectEq("reset flags", 32'd0, rd);
		apbXfer(1'b1, REG_VAL_LO, 32'hA5C3_1E77, rd, err);
		apbXfer(1'b0, REG_VAL_LO, '0, rd, err);
		expectEq("readback val lo", 32'hA5C3_1E77, rd);
		apbXfer(1'b1, REG_VAL_HI, 32'hFFFF_FFFF, rd, err);
		apbXfer(1'b0, REG_VAL_HI, '0, rd, err);
		expectEq("readback val hi", 32'h0000_1FFF, rd); // 13 bits kept.
		apbXfer(1'b1, REG_CTRL, 32'hFFFF_FFFF, rd, err);
		apbXfer(1'b0, REG_CTRL, '0, rd, err);
		expectEq("readback ctrl", 32'h0000_001F, rd);
		endTest();

		beginTest("ir color");
		for (int i = 0; i < 40; i++) begin
			runCmd($sformatf("ircolor rand %0d", i), randomValue(),
				{3'(randomBits(3)), opIrColor}, 1'b1);
		end
		// Limits after the shift, each with sf and lm combinations.
		for (int e = 0; e < 16; e++) begin
			case (e % 4)
				0: edgeVal = 32'h0000_7FFF;
				1: edgeVal = 32'h0000_8000;
				2: edgeVal = 32'hFFFF_8000;
				default: edgeVal = 32'hFFFF_7FFF;
			endcase
			v = e[2] ? ((widen(edgeVal) << 12) | 45'(randomBits(12))) : widen(edgeVal);
			runCmd($sformatf("ircolor edge %0d", e), v, {nextBit(), e[3], e[2], opIrColor}, 1'b1);
		end
		endTest();

		beginTest("low clamps");
		for (int op = 1; op < 4; op++) begin
			for (int k = 0; k < 6; k++) begin
				case (k)
					0: v = widen(32'(clampLimit(op, 1'b0) - 1));
					1: v = widen(32'(clampLimit(op, 1'b0)));
					2: v = widen(32'(clampLimit(op, 1'b1)));
					3: v = widen(32'(clampLimit(op, 1'b1) + 1));
					4: v = 45'h0100_0000_0123; // Bit 40 set, positive.
					default: v = 45'h1EF0_0000_1234; // Bit 40 clear, negative.
				endcase
				runCmd($sformatf("op%0d bound %0d", op, k), v, {3'(randomBits(3)), 2'(op)}, 1'b1);
			end
		end
		endTest();

		beginTest("sticky flags");
		runCmd("sticky otz", widen(32'hFFFF_FFFF), {3'd0, opOtz}, 1'b0);
		runCmd("sticky sxy", 45'h0100_0000_0123, {3'd0, opSxy}, 1'b0); // OR of both.
		apbXfer(1'b1, REG_FLAGS, 32'hFFFF_FFFF, rd, err);
		stickyExp = '0;
		apbXfer(1'b0, REG_FLAGS, '0, rd, err);
		expectEq("sticky cleared", 32'd0, rd);
		endTest();

		beginTest("backpressure");
		for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
			bpVal[i]  = randomValue();
			bpCtrl[i] = 5'(randomBits(5));
			sendCmd(bpVal[i], bpCtrl[i], err);
			expectEq($sformatf("backpressure cmd %0d slverr", i), 32'(i >= FIFO_DEPTH + 2),
				{31'd0, err});
		end
		// FIFO full, stage 2 busy, slot loaded.
		apbXfer(1'b0, REG_STATUS, '0, rd, err);
		expectEq("backpressure status", {23'd0, 1'b1, 4'(FIFO_DEPTH), 3'd0, 1'b1}, rd);
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			expRes    = clipModel(bpVal[i], bpCtrl[i]);
			stickyExp = stickyExp | expRes[5:0];
			waitReady($sformatf("backpressure read %0d", i));
			apbXfer(1'b0, REG_RESULT, '0, rd, err);
			expectEq($sformatf("backpressure result %0d", i), resultWord(expRes), rd);
		end
		apbXfer(1'b0, REG_FLAGS, '0, rd, err);
		expectEq("backpressure flags", {26'd0, stickyExp}, rd);
		apbXfer(1'b0, REG_STATUS, '0, rd, err);
		expectEq("backpressure drained", 32'd0, rd);
		endTest();

		beginTest("empty read");
		apbXfer(1'b0, REG_RESULT, '0, rd, err);
		expectEq("empty read slverr", 32'd1, {31'd0, err});
		expectEq("empty read data", 32'd0, rd);
		endTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
